//--- verilog/loader_pkg.sv
// Loader package with sizes, index codes, base addresses, CRT and BASIC constants, bus structs
package loader_pkg;

	// ======================================================================
	// Sizes and file index codes
	// ======================================================================
	localparam int ADDR_W = 25;

	localparam logic [7:0] IDX_PRG     = 8'h04;
	localparam logic [7:0] IDX_CRT     = 8'h05;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;
	localparam logic [7:0] IDX_TAP     = 8'h06;

	// Memory regions for cartridge and tape images
	localparam logic [ADDR_W-1:0] CART_BASE = 25'h100000;
	localparam logic [ADDR_W-1:0] TAP_BASE  = 25'h200000;

	// ======================================================================
	// CRT header layout
	// ======================================================================
	localparam logic [ADDR_W-1:0] CRT_ID_HI      = 25'h16;
	localparam logic [ADDR_W-1:0] CRT_ID_LO      = 25'h17;
	localparam logic [ADDR_W-1:0] CRT_EXROM      = 25'h18;
	localparam logic [ADDR_W-1:0] CRT_GAME       = 25'h19;
	localparam logic [ADDR_W-1:0] CRT_CHIP_START = 25'h40;

	// ======================================================================
	// BASIC zero-page pointers patched after a PRG load
	// ======================================================================
	localparam logic [8:0] MEMINIT_END = 9'h100;

	localparam logic [7:0] BASIC_TXT_LO  = 8'h2B;
	localparam logic [7:0] BASIC_TXT_HI  = 8'h2C;
	localparam logic [7:0] BASIC_SAVE_LO = 8'hAC;
	localparam logic [7:0] BASIC_SAVE_HI = 8'hAD;

	// VAR, ARY, STR and LOAD_END low bytes, each high byte follows
	localparam logic [3:0][7:0] BASIC_END_PTRS = {8'hAE, 8'h31, 8'h2F, 8'h2D};

	// ======================================================================
	// Struct types
	// ======================================================================
	typedef struct packed {
		logic              download;
		logic              wr;
		logic [7:0]        index;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} dl_byte_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_wr_t;

	typedef struct packed {
		logic              ce;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_req_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
		logic        attached;
	} cart_info_t;

	typedef struct packed {
		logic        wr;
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] laddr;
		logic [15:0] size;
	} cart_bank_t;

endpackage

//--- verilog/prg_injector.sv
// PRG loader: load address capture, data write requests and BASIC pointer patch pass
module prg_injector (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  loader_pkg::dl_byte_t dl_i,
	input  logic                 busy_i,
	output loader_pkg::mem_wr_t  wr_o
);

	logic        is_prg;
	logic        dl_prev;
	logic [15:0] load_addr;
	logic [15:0] end_addr;
	logic        patch_active;
	logic [8:0]  patch_addr;
	logic        patch_step;
	logic        patch_done;
	logic [8:0]  patch_entry;

	// Value written at a zero-page location, bit 8 marks a pointer hit
	function automatic logic [8:0] patch_lookup(input logic [7:0] loc, input logic [15:0] end_val);
		logic [8:0] entry;
		int         i;
		entry = 9'd0;
		case (loc)
			loader_pkg::BASIC_TXT_LO:  entry = {1'b1, 8'h01};
			loader_pkg::BASIC_TXT_HI:  entry = {1'b1, 8'h08};
			loader_pkg::BASIC_SAVE_LO: entry = {1'b1, 8'h00};
			loader_pkg::BASIC_SAVE_HI: entry = {1'b1, 8'h00};
			default:                   entry = 9'd0;
		endcase
		// All end pointers receive the load end address
		for (i = 0; i < 4; i++) begin
			if (loc == loader_pkg::BASIC_END_PTRS[i])
				entry = {1'b1, end_val[7:0]};
			if (loc == loader_pkg::BASIC_END_PTRS[i] + 8'd1)
				entry = {1'b1, end_val[15:8]};
		end
		return entry;
	endfunction

	assign is_prg      = (dl_i.index == loader_pkg::IDX_PRG);
	assign patch_step  = patch_active & ~busy_i;
	assign patch_done  = (patch_addr == loader_pkg::MEMINIT_END);
	assign patch_entry = patch_lookup(patch_addr[7:0], end_addr);

	// Data bytes go straight out; the patch pass only writes at pointer hits
	always_comb begin
		wr_o.valid = 1'b0;
		wr_o.addr  = {{(loader_pkg::ADDR_W-16){1'b0}}, load_addr};
		wr_o.data  = dl_i.data;
		if (dl_i.wr && is_prg && dl_i.addr > 25'd1) begin
			wr_o.valid = 1'b1;
		end else if (patch_step && !patch_done) begin
			wr_o.valid = patch_entry[8];
			wr_o.addr  = {{(loader_pkg::ADDR_W-9){1'b0}}, patch_addr};
			wr_o.data  = patch_entry[7:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_prev      <= 1'b0;
			patch_active <= 1'b0;
			patch_addr   <= 9'd0;
		end else begin
			dl_prev <= dl_i.download;

			if (dl_i.wr && is_prg) begin
				// Two-byte header, low byte first
				if (dl_i.addr == 25'd0) begin
					load_addr[7:0] <= dl_i.data;
					end_addr[7:0]  <= dl_i.data;
				end else if (dl_i.addr == 25'd1) begin
					load_addr[15:8] <= dl_i.data;
					end_addr[15:8]  <= dl_i.data;
				end else begin
					load_addr <= load_addr + 16'd1;
					end_addr  <= end_addr + 16'd1;
				end
			end

			// End of file starts the zero-page walk
			if (dl_prev && !dl_i.download && is_prg && !patch_active) begin
				patch_active <= 1'b1;
				patch_addr   <= 9'd0;
			end

			// One location per free slot, hit or skip
			if (patch_step) begin
				if (patch_done)
					patch_active <= 1'b0;
				else
					patch_addr <= patch_addr + 9'd1;
			end
		end
	end

endmodule

//--- verilog/crt_parser.sv
// CRT loader: header capture, CHIP packet parsing, 8 KB alignment and cartridge write requests
module crt_parser (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_byte_t   dl_i,
	output loader_pkg::mem_wr_t    wr_o,
	output loader_pkg::cart_info_t cart_o,
	output loader_pkg::cart_bank_t bank_o
);

	logic                          is_crt;
	logic                          dl_prev;
	logic [loader_pkg::ADDR_W-1:0] wr_addr;
	logic [31:0]                   blk_len;
	logic [3:0]                    hdr_cnt;
	logic                          in_chips;
	logic                          chip_start;
	logic                          in_header;
	logic                          in_data;

	assign is_crt = (dl_i.index == loader_pkg::IDX_CRT) ||
	                (dl_i.index == loader_pkg::IDX_CRT_ALT);

	// Packet state decode for the current byte
	assign in_chips   = (dl_i.addr >= loader_pkg::CRT_CHIP_START);
	assign chip_start = in_chips && (blk_len == 32'd0) && (hdr_cnt == 4'd0);
	assign in_header  = in_chips && (hdr_cnt != 4'd0);
	assign in_data    = in_chips && (hdr_cnt == 4'd0) && (blk_len != 32'd0);

	always_comb begin
		wr_o.valid = dl_i.wr && is_crt && in_data;
		wr_o.addr  = wr_addr;
		wr_o.data  = dl_i.data;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_prev         <= 1'b0;
			blk_len         <= 32'd0;
			hdr_cnt         <= 4'd0;
			cart_o.attached <= 1'b0;
			bank_o.wr       <= 1'b0;
		end else begin
			dl_prev   <= dl_i.download;
			bank_o.wr <= 1'b0;

			// Detached while loading, attached once the file is complete
			if (is_crt && dl_prev != dl_i.download)
				cart_o.attached <= dl_prev;

			if (dl_i.wr && is_crt) begin
				if (dl_i.addr == '0) begin
					wr_addr <= loader_pkg::CART_BASE;
					blk_len <= 32'd0;
					hdr_cnt <= 4'd0;
				end

				// ==========================================================
				// File header fields
				// ==========================================================
				if (dl_i.addr == loader_pkg::CRT_ID_HI)
					cart_o.id[15:8] <= dl_i.data;
				if (dl_i.addr == loader_pkg::CRT_ID_LO)
					cart_o.id[7:0] <= dl_i.data;
				if (dl_i.addr == loader_pkg::CRT_EXROM)
					cart_o.exrom <= dl_i.data;
				if (dl_i.addr == loader_pkg::CRT_GAME)
					cart_o.game <= dl_i.data;

				// ==========================================================
				// CHIP packets
				// ==========================================================
				if (chip_start) begin
					hdr_cnt <= 4'd1;
					// Each bank starts on an 8 KB boundary
					if (wr_addr[12:0] != 13'd0)
						wr_addr <= {wr_addr[loader_pkg::ADDR_W-1:13] + 1'b1, 13'd0};
				end else if (in_header) begin
					hdr_cnt <= hdr_cnt + 4'd1;
					case (hdr_cnt)
						4'd4:  blk_len[31:24] <= dl_i.data;
						4'd5:  blk_len[23:16] <= dl_i.data;
						4'd6:  blk_len[15:8]  <= dl_i.data;
						4'd7:  blk_len[7:0]   <= dl_i.data;
						// Packet length includes its 16 header bytes
						4'd8:  blk_len <= blk_len - 32'd16;
						4'd9:  bank_o.bank_type <= dl_i.data;
						4'd10: bank_o.bank_num[15:8] <= dl_i.data;
						4'd11: bank_o.bank_num[7:0]  <= dl_i.data;
						4'd12: bank_o.laddr[15:8] <= dl_i.data;
						4'd13: bank_o.laddr[7:0]  <= dl_i.data;
						4'd14: bank_o.size[15:8] <= dl_i.data;
						4'd15: begin
							bank_o.size[7:0] <= dl_i.data;
							bank_o.wr        <= 1'b1;
						end
						default: ;
					endcase
				end else if (in_data) begin
					blk_len <= blk_len - 32'd1;
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/tap_capture.sv
// TAP loader: tape data write requests and tape length register
module tap_capture (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  loader_pkg::dl_byte_t          dl_i,
	output loader_pkg::mem_wr_t           wr_o,
	output logic [loader_pkg::ADDR_W-1:0] tape_len_o
);

	logic                          is_tap;
	logic                          dl_prev;
	logic [loader_pkg::ADDR_W-1:0] wr_addr;
	logic [loader_pkg::ADDR_W-1:0] cur_addr;

	assign is_tap = (dl_i.index == loader_pkg::IDX_TAP);

	// First byte of the file restarts at the tape base
	assign cur_addr = (dl_i.addr == '0) ? loader_pkg::TAP_BASE : wr_addr;

	always_comb begin
		wr_o.valid = dl_i.wr && is_tap;
		wr_o.addr  = cur_addr;
		wr_o.data  = dl_i.data;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_prev    <= 1'b0;
			tape_len_o <= '0;
		end else begin
			dl_prev <= dl_i.download;

			if (dl_i.wr && is_tap)
				wr_addr <= cur_addr + 1'b1;

			// Length is the distance covered from the base
			if (is_tap && dl_prev && !dl_i.download)
				tape_len_o <= wr_addr - loader_pkg::TAP_BASE;
		end
	end

endmodule

//--- verilog/mem_slot.sv
// Single pending write slot issued in the io-cycle idle window, with host wait
module mem_slot (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 io_cycle_i,
	input  loader_pkg::mem_wr_t  prg_i,
	input  loader_pkg::mem_wr_t  crt_i,
	input  loader_pkg::mem_wr_t  tap_i,
	output logic                 busy_o,
	output loader_pkg::mem_req_t mem_req_o
);

	loader_pkg::mem_wr_t           sel;
	logic                          pend;
	logic [loader_pkg::ADDR_W-1:0] pend_addr;
	logic [7:0]                    pend_data;
	logic                          io_prev;
	logic                          io_fall;
	logic                          io_high2;

	// Fixed priority, only one loader is active per file
	always_comb begin
		if (prg_i.valid)
			sel = prg_i;
		else if (crt_i.valid)
			sel = crt_i;
		else
			sel = tap_i;
	end

	assign io_fall  = io_prev & ~io_cycle_i;
	assign io_high2 = io_prev & io_cycle_i;
	assign busy_o   = pend;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pend         <= 1'b0;
			io_prev      <= 1'b0;
			mem_req_o.ce <= 1'b0;
			mem_req_o.we <= 1'b0;
		end else begin
			io_prev <= io_cycle_i;

			// Bus handed back to the computer
			if (io_high2) begin
				mem_req_o.ce <= 1'b0;
				mem_req_o.we <= 1'b0;
			end

			// Idle window opens on the falling io-cycle edge
			if (io_fall && pend) begin
				mem_req_o.ce   <= 1'b1;
				mem_req_o.we   <= 1'b1;
				mem_req_o.addr <= pend_addr;
				mem_req_o.data <= pend_data;
				pend           <= 1'b0;
			end

			if (sel.valid) begin
				pend      <= 1'b1;
				pend_addr <= sel.addr;
				pend_data <= sel.data;
			end
		end
	end

endmodule

//--- verilog/c64_loader.sv
// Download path top level: PRG, CRT and TAP loaders sharing one memory write slot
module c64_loader (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  loader_pkg::dl_byte_t          dl_i,
	input  logic                          io_cycle_i,
	output logic                          ioctl_wait_o,
	output loader_pkg::mem_req_t          mem_req_o,
	output loader_pkg::cart_info_t        cart_o,
	output loader_pkg::cart_bank_t        bank_o,
	output logic [loader_pkg::ADDR_W-1:0] tape_len_o
);

	loader_pkg::mem_wr_t prg_wr;
	loader_pkg::mem_wr_t crt_wr;
	loader_pkg::mem_wr_t tap_wr;

	prg_injector u_prg (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.dl_i    (dl_i),
		.busy_i  (ioctl_wait_o),
		.wr_o    (prg_wr)
	);

	crt_parser u_crt (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.dl_i    (dl_i),
		.wr_o    (crt_wr),
		.cart_o  (cart_o),
		.bank_o  (bank_o)
	);

	tap_capture u_tap (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.dl_i       (dl_i),
		.wr_o       (tap_wr),
		.tape_len_o (tape_len_o)
	);

	// Slot busy doubles as the host wait level
	mem_slot u_slot (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.prg_i      (prg_wr),
		.crt_i      (crt_wr),
		.tap_i      (tap_wr),
		.busy_o     (ioctl_wait_o),
		.mem_req_o  (mem_req_o)
	);

endmodule

//--- testbench/loader_model.svh
// Reference model with case record, file image builders, expected write list and bank records
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

typedef enum logic [1:0] {KIND_PRG, KIND_CRT, KIND_TAP} file_kind_t;

// One table row, param is the load address for PRG and the chip count for CRT
typedef struct packed {
	file_kind_t  kind;
	logic [15:0] len;
	logic [15:0] param;
	logic [15:0] id;
	logic [7:0]  exrom;
	logic [7:0]  game;
	logic        slow;
} case_t;

function automatic int file_len(input case_t c);
	if (c.kind == KIND_PRG)
		return 2 + int'(c.len);
	if (c.kind == KIND_CRT)
		return 64 + int'(c.param) * (16 + int'(c.len));
	return int'(c.len);
endfunction

task automatic add_write(input logic [loader_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
	loader_pkg::mem_req_t w;
	w = '{1'b1, 1'b1, addr, data};
	exp_wr_q.push_back(w);
endtask

task automatic build_prg(input case_t c);
	logic [15:0] addr;
	logic [7:0]  b;
	int          k;
	file_q.push_back(c.param[7:0]);
	file_q.push_back(c.param[15:8]);
	addr = c.param;
	for (k = 0; k < int'(c.len); k++) begin
		b = 8'($urandom);
		file_q.push_back(b);
		add_write({9'd0, addr}, b);
		addr = addr + 16'd1;
	end
	// Zero-page patch in ascending order, addr now holds the end address
	add_write(25'h2B, 8'h01);
	add_write(25'h2C, 8'h08);
	for (k = 0; k < 3; k++) begin
		add_write(25'h2D + 25'(2 * k), addr[7:0]);
		add_write(25'h2E + 25'(2 * k), addr[15:8]);
	end
	add_write(25'hAC, 8'h00);
	add_write(25'hAD, 8'h00);
	add_write(25'hAE, addr[7:0]);
	add_write(25'hAF, addr[15:8]);
endtask

task automatic build_crt(input case_t c);
	logic [loader_pkg::ADDR_W-1:0] addr;
	logic [31:0]                   pkt_len;
	logic [127:0]                  chip_hdr;
	loader_pkg::cart_bank_t        rec;
	logic [7:0]                    b;
	int                            k;
	int                            n;
	for (k = 0; k < 64; k++) begin
		case (k)
			'h16:    b = c.id[15:8];
			'h17:    b = c.id[7:0];
			'h18:    b = c.exrom;
			'h19:    b = c.game;
			default: b = 8'($urandom);
		endcase
		file_q.push_back(b);
	end
	addr    = loader_pkg::CART_BASE;
	pkt_len = 32'(c.len) + 32'd16;
	for (n = 0; n < int'(c.param); n++) begin
		rec = '{1'b1, (n % 2 == 1) ? 8'h02 : 8'h00, 16'(n),
			(n % 2 == 1) ? 16'hA000 : 16'h8000, c.len};
		exp_bank_q.push_back(rec);
		// CHIP signature, packet length, type, bank, load address and size
		chip_hdr = {32'h43484950, pkt_len, 8'h00, rec.bank_type, rec.bank_num,
			rec.laddr, rec.size};
		for (k = 15; k >= 0; k--)
			file_q.push_back(chip_hdr[8*k +: 8]);
		// Bank data starts on the next 8 KB boundary
		if (addr[12:0] != 13'd0)
			addr = {addr[loader_pkg::ADDR_W-1:13] + 12'd1, 13'd0};
		for (k = 0; k < int'(c.len); k++) begin
			b = 8'($urandom);
			file_q.push_back(b);
			add_write(addr, b);
			addr = addr + 25'd1;
		end
	end
endtask

task automatic build_tap(input case_t c);
	logic [7:0] b;
	int         k;
	for (k = 0; k < int'(c.len); k++) begin
		b = 8'($urandom);
		file_q.push_back(b);
		add_write(loader_pkg::TAP_BASE + 25'(k), b);
	end
endtask

`endif

//--- testbench/tb_c64_loader.sv
// Testbench for the download path with case table, host driver, io-cycle source, monitor and checks
module tb_c64_loader;

	localparam int N_CASES = 6;

	logic                          clk_sys;
	logic                          reset_n;
	loader_pkg::dl_byte_t          dl;
	logic                          io_cycle;
	logic                          ioctl_wait;
	loader_pkg::mem_req_t          mem_req;
	loader_pkg::cart_info_t        cart;
	loader_pkg::cart_bank_t        bank;
	logic [loader_pkg::ADDR_W-1:0] tape_len;

	logic [7:0]             file_q[$];
	loader_pkg::mem_req_t   exp_wr_q[$];
	loader_pkg::mem_req_t   got_wr_q[$];
	loader_pkg::cart_bank_t exp_bank_q[$];
	loader_pkg::cart_bank_t got_bank_q[$];
	logic                   ce_last;
	logic                   slow_io;
	int                     errors;
	int                     case_errors;
	int                     passed;

	`include "loader_model.svh"

	// Kind, length, load address or chips, id, exrom, game, sparse io windows
	case_t cases [N_CASES] = '{
		'{KIND_PRG, 16'd40, 16'h0801, 16'h0000, 8'h00, 8'h00, 1'b0},
		'{KIND_CRT, 16'd20, 16'd3,    16'h0000, 8'h00, 8'h01, 1'b0},
		'{KIND_TAP, 16'd48, 16'h0000, 16'h0000, 8'h00, 8'h00, 1'b0},
		'{KIND_PRG, 16'd16, 16'hC000, 16'h0000, 8'h00, 8'h00, 1'b1},
		'{KIND_CRT, 16'd12, 16'd2,    16'h0013, 8'h01, 8'h00, 1'b1},
		'{KIND_TAP, 16'd24, 16'h0000, 16'h0000, 8'h00, 8'h00, 1'b1}
	};

	c64_loader i_dut (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.dl_i         (dl),
		.io_cycle_i   (io_cycle),
		.ioctl_wait_o (ioctl_wait),
		.mem_req_o    (mem_req),
		.cart_o       (cart),
		.bank_o       (bank),
		.tape_len_o   (tape_len)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Computer bus activity as random high and low runs
	initial begin
		int run;
		io_cycle = 1'b0;
		@(posedge reset_n);
		forever begin
			run = slow_io ? 8 + int'($urandom % 9) : 2 + int'($urandom % 5);
			repeat (run) @(negedge clk_sys);
			io_cycle = 1'b1;
			run = 2 + int'($urandom % 5);
			repeat (run) @(negedge clk_sys);
			io_cycle = 1'b0;
		end
	end

	// Write and bank record capture, sampled away from the active edge
	always @(negedge clk_sys) begin
		if (!reset_n) begin
			ce_last <= 1'b0;
		end else begin
			if (mem_req.ce && !ce_last)
				got_wr_q.push_back(mem_req);
			if (bank.wr)
				got_bank_q.push_back(bank);
			ce_last <= mem_req.ce;
		end
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_mem_wr(input loader_pkg::mem_req_t got, input loader_pkg::mem_req_t exp);
		if (got !== exp) begin
			$display("FAIL mem_req_o got addr %h data %h, expected addr %h data %h",
				got.addr, got.data, exp.addr, exp.data);
			case_errors++;
		end
	endtask

	task automatic check_bank(input loader_pkg::cart_bank_t got, input loader_pkg::cart_bank_t exp);
		if (got !== exp) begin
			$display("FAIL bank_o got %h expected %h", got, exp);
			case_errors++;
		end
	endtask

	task automatic check_cart(input loader_pkg::cart_info_t got, input loader_pkg::cart_info_t exp);
		if (got !== exp) begin
			$display("FAIL cart_o got %h expected %h", got, exp);
			case_errors++;
		end
	endtask

	task automatic check_len(input logic [loader_pkg::ADDR_W-1:0] got,
		input logic [loader_pkg::ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL tape_len_o got %h expected %h", got, exp);
			case_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			case_errors++;
		end
	endtask

	// Host side, one wr strobe per byte while the wait level is low
	task automatic send_file(input case_t c);
		int k;
		@(negedge clk_sys);
		case (c.kind)
			KIND_PRG: dl.index = loader_pkg::IDX_PRG;
			KIND_CRT: dl.index = c.slow ? loader_pkg::IDX_CRT_ALT : loader_pkg::IDX_CRT;
			default:  dl.index = loader_pkg::IDX_TAP;
		endcase
		dl.download = 1'b1;
		for (k = 0; k < file_q.size(); k++) begin
			@(negedge clk_sys);
			while (ioctl_wait)
				@(negedge clk_sys);
			dl.wr   = 1'b1;
			dl.addr = 25'(k);
			dl.data = file_q[k];
			@(negedge clk_sys);
			dl.wr = 1'b0;
		end
		@(negedge clk_sys);
		dl.download = 1'b0;
	endtask

	task automatic run_case(input int n);
		case_t      c;
		file_kind_t kind;
		int         k;
		c    = cases[n];
		kind = c.kind;
		case_errors = 0;
		file_q.delete();
		exp_wr_q.delete();
		got_wr_q.delete();
		exp_bank_q.delete();
		got_bank_q.delete();
		slow_io = c.slow;
		case (kind)
			KIND_PRG: build_prg(c);
			KIND_CRT: build_crt(c);
			default:  build_tap(c);
		endcase
		send_file(c);
		while (got_wr_q.size() < exp_wr_q.size())
			@(negedge clk_sys);
		// Quiet for a full zero-page walk so late extra writes show up
		while (ioctl_wait)
			@(negedge clk_sys);
		repeat (int'(loader_pkg::MEMINIT_END)) @(negedge clk_sys);
		if (got_wr_q.size() != exp_wr_q.size()) begin
			$display("Memory saw %0d writes but %0d were expected", got_wr_q.size(),
				exp_wr_q.size());
			case_errors++;
		end
		for (k = 0; k < exp_wr_q.size() && k < got_wr_q.size(); k++)
			check_mem_wr(got_wr_q[k], exp_wr_q[k]);
		if (kind == KIND_CRT) begin
			if (got_bank_q.size() != exp_bank_q.size()) begin
				$display("Cartridge gave %0d bank records but %0d were expected",
					got_bank_q.size(), exp_bank_q.size());
				case_errors++;
			end
			for (k = 0; k < exp_bank_q.size() && k < got_bank_q.size(); k++)
				check_bank(got_bank_q[k], exp_bank_q[k]);
			check_cart(cart, '{c.id, c.exrom, c.game, 1'b1});
		end
		if (kind == KIND_TAP)
			check_len(tape_len, 25'(file_q.size()));
		$display("Case %0d %s with %0d file bytes and %0d writes: %s", n, kind.name(),
			file_q.size(), got_wr_q.size(), (case_errors == 0) ? "ok" : "errors found");
		if (case_errors == 0)
			passed++;
		errors += case_errors;
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		int n;
		void'($urandom(95));
		errors  = 0;
		passed  = 0;
		slow_io = 1'b0;
		dl      = '0;
		reset_n = 1'b0;
		repeat (10) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);
		case_errors = 0;
		check_flag("mem_req_o.ce", mem_req.ce, 1'b0);
		check_flag("cart_o.attached", cart.attached, 1'b0);
		check_flag("ioctl_wait_o", ioctl_wait, 1'b0);
		$display("Idle state after reset: %s", (case_errors == 0) ? "ok" : "errors found");
		errors += case_errors;
		for (n = 0; n < N_CASES; n++)
			run_case(n);
		$display("Summary: %0d cases, %0d without errors, %0d errors", N_CASES, passed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Limit scales with the total download size
	initial begin
		int total;
		int n;
		total = 0;
		for (n = 0; n < N_CASES; n++)
			total += file_len(cases[n]);
		repeat (total * 40 + 2000) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the DUT stopped making progress", total * 40 + 2000);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+testbench
verilog/loader_pkg.sv
verilog/prg_injector.sv
verilog/crt_parser.sv
verilog/tap_capture.sv
verilog/mem_slot.sv
verilog/c64_loader.sv
testbench/tb_c64_loader.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_c64_loader -f all.f -o sim_c64_loader
./obj_dir/sim_c64_loader > sim.log
cat sim.log
if grep -q "Checks failed" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"
